// ==== hw/attn_score_buffer.sv ====
`default_nettype none

module attn_score_buffer (
    input  logic                                   s_clk,
    input  logic                                   i_rst_n,
    input  logic [spk_attn_pkg::SCORE_ROW_W-1:0]   i_score_data,
    input  logic                                   i_score_valid,
    input  logic [spk_attn_pkg::TOK_AW-1:0]        i_rd_j,
    input  logic                                   i_row_done,
    output logic                                   o_attn_ready,
    output logic                                   o_attn_empty,
    output logic [spk_attn_pkg::SCORE_ROW_W-1:0]   o_rd_data
);

    logic [spk_attn_pkg::SCORE_ROW_W-1:0] slot_mem [2][spk_attn_pkg::TOKENS];

    logic                            wr_slot;
    logic                            rd_slot;
    logic [spk_attn_pkg::TOK_AW-1:0] wr_pos;
    logic [1:0]                      full_cnt;
    logic                            row_fill;

    assign row_fill     = i_score_valid && (wr_pos == spk_attn_pkg::TOKENS - 1);
    assign o_attn_ready = (full_cnt < 2'd2);            // the write slot is free.
    assign o_attn_empty = (full_cnt == 2'd0);
    assign o_rd_data    = slot_mem[rd_slot][i_rd_j];    // oldest full row.

    always_ff @(posedge s_clk) begin
        if (i_score_valid) begin
            slot_mem[wr_slot][wr_pos] <= i_score_data;
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_slot  <= 1'b0;
            rd_slot  <= 1'b0;
            wr_pos   <= '0;
            full_cnt <= 2'd0;
        end else begin
            if (i_score_valid) begin
                wr_pos <= wr_pos + 1'b1;                // wraps after the eighth pair.
            end
            if (row_fill) begin
                wr_slot <= ~wr_slot;
            end
            if (i_row_done) begin
                rd_slot <= ~rd_slot;
            end
            full_cnt <= full_cnt + {1'b0, row_fill} - {1'b0, i_row_done};
        end
    end

endmodule

`default_nettype wire

// ==== hw/mm_calculator.sv ====
`default_nettype none

module mm_calculator (
    input  logic                                   s_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_start,
    input  logic                                   i_attn_empty,
    input  logic [spk_attn_pkg::SCORE_ROW_W-1:0]   i_attn_data,
    input  logic [spk_attn_pkg::ROW_W-1:0]         i_v_row,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_attn_rd_j,
    output logic                                   o_attn_row_done,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_v_addr,
    output logic [spk_attn_pkg::ROW_W-1:0]         o_spike_data,
    output logic                                   o_spike_valid,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_spike_row,
    output logic                                   o_done,
    output logic                                   o_busy
);

    logic [2:0]                                 state;
    logic [spk_attn_pkg::TOK_AW-1:0]            row_i;
    logic [$clog2(spk_attn_pkg::EMBED)-1:0]     dim;
    logic [spk_attn_pkg::TOK_AW-1:0]            tok_j;
    logic [spk_attn_pkg::TOK_AW-1:0]            tok_j_d;
    logic                                       acc_vld;
    logic                                       last_dim;
    logic [spk_attn_pkg::PROD_W-1:0]            acc [spk_attn_pkg::TIME_STEPS];
    logic [spk_attn_pkg::MEM_W-1:0]             mem_v;
    logic [spk_attn_pkg::MEM_W-1:0]             sum_v;
    logic [spk_attn_pkg::TIME_STEPS-1:0]        lif_spk;
    logic [spk_attn_pkg::ROW_W-1:0]             spike_reg;

    assign o_v_addr        = tok_j;
    assign o_attn_rd_j     = tok_j_d;                   // score lines up with the V row.
    assign last_dim        = (dim == spk_attn_pkg::EMBED - 1);
    assign o_attn_row_done = (state == spk_attn_pkg::ST_LIF) && last_dim;
    assign o_spike_data    = spike_reg;

    // LIF over the four steps of one dimension, membrane starts at zero.
    always_comb begin
        mem_v   = '0;
        sum_v   = '0;
        lif_spk = '0;
        for (int t = 0; t < spk_attn_pkg::TIME_STEPS; t++) begin
            sum_v      = mem_v + acc[t];
            lif_spk[t] = (sum_v >= spk_attn_pkg::LIF_THRESHOLD);
            mem_v      = lif_spk[t] ? '0 : sum_v;       // hard reset after a spike.
        end
    end

    always_ff @(posedge s_clk) begin
        if (state == spk_attn_pkg::ST_LIF) begin
            for (int t = 0; t < spk_attn_pkg::TIME_STEPS; t++) begin
                spike_reg[t*spk_attn_pkg::EMBED + dim] <= lif_spk[t];
                acc[t] <= '0;
            end
        end else if (acc_vld) begin
            for (int t = 0; t < spk_attn_pkg::TIME_STEPS; t++) begin
                if (i_v_row[t*spk_attn_pkg::EMBED + dim]) begin
                    acc[t] <= acc[t] +
                              i_attn_data[t*spk_attn_pkg::SCORE_W +: spk_attn_pkg::SCORE_W];
                end
            end
        end else if (state == spk_attn_pkg::ST_WAIT) begin
            for (int t = 0; t < spk_attn_pkg::TIME_STEPS; t++) begin
                acc[t] <= '0;
            end
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= spk_attn_pkg::ST_IDLE;
            row_i         <= '0;
            dim           <= '0;
            tok_j         <= '0;
            tok_j_d       <= '0;
            acc_vld       <= 1'b0;
            o_spike_valid <= 1'b0;
            o_spike_row   <= '0;
            o_done        <= 1'b0;
            o_busy        <= 1'b0;
        end else begin
            o_spike_valid <= 1'b0;
            o_done        <= 1'b0;
            acc_vld       <= (state == spk_attn_pkg::ST_ACC);
            tok_j_d       <= tok_j;
            case (state)
                spk_attn_pkg::ST_IDLE: begin
                    if (i_start) begin
                        o_busy <= 1'b1;
                        row_i  <= '0;
                        state  <= spk_attn_pkg::ST_WAIT;
                    end
                end
                spk_attn_pkg::ST_WAIT: begin
                    if (!i_attn_empty) begin
                        dim   <= '0;
                        tok_j <= '0;
                        state <= spk_attn_pkg::ST_ACC;
                    end
                end
                spk_attn_pkg::ST_ACC: begin
                    tok_j <= tok_j + 1'b1;
                    if (tok_j == spk_attn_pkg::TOKENS - 1) begin
                        state <= spk_attn_pkg::ST_DRAIN;  // last V row still in flight.
                    end
                end
                spk_attn_pkg::ST_DRAIN: begin
                    state <= spk_attn_pkg::ST_LIF;
                end
                spk_attn_pkg::ST_LIF: begin
                    if (last_dim) begin
                        o_spike_valid <= 1'b1;
                        o_spike_row   <= row_i;
                        row_i         <= row_i + 1'b1;
                        state <= (row_i == spk_attn_pkg::TOKENS - 1) ?
                                 spk_attn_pkg::ST_FIN : spk_attn_pkg::ST_WAIT;
                    end else begin
                        dim   <= dim + 1'b1;
                        state <= spk_attn_pkg::ST_ACC;
                    end
                end
                spk_attn_pkg::ST_FIN: begin
                    o_done <= 1'b1;
                    o_busy <= 1'b0;
                    state  <= spk_attn_pkg::ST_IDLE;
                end
                default: state <= spk_attn_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/qkv_spike_ram.sv ====
`default_nettype none

module qkv_spike_ram (
    input  logic                              s_clk,
    input  logic                              i_rst_n,
    input  logic                              i_load_valid,
    input  logic [spk_attn_pkg::SEL_W-1:0]    i_load_sel,
    input  logic [spk_attn_pkg::TOK_AW-1:0]   i_load_addr,
    input  logic [spk_attn_pkg::ROW_W-1:0]    i_load_data,
    input  logic [spk_attn_pkg::TOK_AW-1:0]   i_q_addr,
    input  logic [spk_attn_pkg::TOK_AW-1:0]   i_k_addr,
    input  logic [spk_attn_pkg::TOK_AW-1:0]   i_v_addr,
    output logic [spk_attn_pkg::ROW_W-1:0]    o_q_row,
    output logic [spk_attn_pkg::ROW_W-1:0]    o_k_row,
    output logic [spk_attn_pkg::ROW_W-1:0]    o_v_row
);

    logic [spk_attn_pkg::ROW_W-1:0] q_mem [spk_attn_pkg::TOKENS];
    logic [spk_attn_pkg::ROW_W-1:0] k_mem [spk_attn_pkg::TOKENS];
    logic [spk_attn_pkg::ROW_W-1:0] v_mem [spk_attn_pkg::TOKENS];

    always_ff @(posedge s_clk) begin
        if (i_load_valid) begin
            case (i_load_sel)
                spk_attn_pkg::SEL_Q: q_mem[i_load_addr] <= i_load_data;
                spk_attn_pkg::SEL_K: k_mem[i_load_addr] <= i_load_data;
                spk_attn_pkg::SEL_V: v_mem[i_load_addr] <= i_load_data;
                default: ;                                  // code 3 writes nothing.
            endcase
        end
    end

    // one cycle read latency on all three ports.
    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_q_row <= '0;
            o_k_row <= '0;
            o_v_row <= '0;
        end else begin
            o_q_row <= q_mem[i_q_addr];
            o_k_row <= k_mem[i_k_addr];
            o_v_row <= v_mem[i_v_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/spike_accumulation.sv ====
`default_nettype none

module spike_accumulation (
    input  logic                                   s_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_start,
    input  logic [spk_attn_pkg::ROW_W-1:0]         i_q_row,
    input  logic [spk_attn_pkg::ROW_W-1:0]         i_k_row,
    input  logic                                   i_attn_ready,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_q_addr,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_k_addr,
    output logic [spk_attn_pkg::SCORE_ROW_W-1:0]   o_score_data,
    output logic                                   o_score_valid,
    output logic                                   o_busy
);

    logic [2*spk_attn_pkg::TOK_AW-1:0] pair_cnt;   // query in the upper half, key in the lower.
    logic                              rd_valid;
    logic                              fire;

    assign o_q_addr = pair_cnt[2*spk_attn_pkg::TOK_AW-1 -: spk_attn_pkg::TOK_AW];
    assign o_k_addr = pair_cnt[spk_attn_pkg::TOK_AW-1:0];

    // a score leaves only when the buffer can take it.
    assign fire          = rd_valid & i_attn_ready;
    assign o_score_valid = fire;

    // per step, count dimensions where query and key both spike.
    always_comb begin
        o_score_data = '0;
        for (int t = 0; t < spk_attn_pkg::TIME_STEPS; t++) begin
            for (int d = 0; d < spk_attn_pkg::EMBED; d++) begin
                o_score_data[t*spk_attn_pkg::SCORE_W +: spk_attn_pkg::SCORE_W] =
                    o_score_data[t*spk_attn_pkg::SCORE_W +: spk_attn_pkg::SCORE_W] +
                    (i_q_row[t*spk_attn_pkg::EMBED + d] & i_k_row[t*spk_attn_pkg::EMBED + d]);
            end
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy   <= 1'b0;
            pair_cnt <= '0;
            rd_valid <= 1'b0;
        end else if (!o_busy) begin
            rd_valid <= 1'b0;
            if (i_start) begin
                o_busy   <= 1'b1;
                pair_cnt <= '0;
            end
        end else if (fire) begin
            rd_valid <= 1'b0;                           // new address, wait for the RAM.
            pair_cnt <= pair_cnt + 1'b1;
            if (pair_cnt == spk_attn_pkg::TOKENS * spk_attn_pkg::TOKENS - 1) begin
                o_busy <= 1'b0;
            end
        end else begin
            rd_valid <= 1'b1;                           // rows for pair_cnt arrive next cycle.
        end
    end

endmodule

`default_nettype wire

// ==== hw/spike_attn_top.sv ====
`default_nettype none

module spike_attn_top (
    input  logic                                   s_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_load_valid,
    input  logic [spk_attn_pkg::SEL_W-1:0]         i_load_sel,
    input  logic [spk_attn_pkg::TOK_AW-1:0]        i_load_addr,
    input  logic [spk_attn_pkg::ROW_W-1:0]         i_load_data,
    input  logic                                   i_start,
    output logic                                   o_busy,
    output logic                                   o_score_valid,
    output logic [spk_attn_pkg::SCORE_ROW_W-1:0]   o_score_data,
    output logic                                   o_spike_valid,
    output logic [spk_attn_pkg::TOK_AW-1:0]        o_spike_row,
    output logic [spk_attn_pkg::ROW_W-1:0]         o_spike_data,
    output logic                                   o_done
);

    logic [spk_attn_pkg::TOK_AW-1:0]      q_addr;
    logic [spk_attn_pkg::TOK_AW-1:0]      k_addr;
    logic [spk_attn_pkg::TOK_AW-1:0]      v_addr;
    logic [spk_attn_pkg::ROW_W-1:0]       q_row;
    logic [spk_attn_pkg::ROW_W-1:0]       k_row;
    logic [spk_attn_pkg::ROW_W-1:0]       v_row;
    logic                                 attn_ready;
    logic                                 attn_empty;
    logic                                 attn_row_done;
    logic [spk_attn_pkg::TOK_AW-1:0]      attn_rd_j;
    logic [spk_attn_pkg::SCORE_ROW_W-1:0] attn_data;
    logic                                 acc_busy;
    logic                                 calc_busy;
    logic                                 start_q;

    assign o_busy  = acc_busy | calc_busy;
    assign start_q = i_start & ~o_busy;                 // a start during a run is dropped.

    qkv_spike_ram u_qkv_ram (
        .s_clk        (s_clk),
        .i_rst_n      (i_rst_n),
        .i_load_valid (i_load_valid),
        .i_load_sel   (i_load_sel),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_q_addr     (q_addr),
        .i_k_addr     (k_addr),
        .i_v_addr     (v_addr),
        .o_q_row      (q_row),
        .o_k_row      (k_row),
        .o_v_row      (v_row)
    );

    spike_accumulation u_accum (
        .s_clk         (s_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start_q),
        .i_q_row       (q_row),
        .i_k_row       (k_row),
        .i_attn_ready  (attn_ready),
        .o_q_addr      (q_addr),
        .o_k_addr      (k_addr),
        .o_score_data  (o_score_data),
        .o_score_valid (o_score_valid),
        .o_busy        (acc_busy)
    );

    attn_score_buffer u_score_buf (
        .s_clk         (s_clk),
        .i_rst_n       (i_rst_n),
        .i_score_data  (o_score_data),
        .i_score_valid (o_score_valid),
        .i_rd_j        (attn_rd_j),
        .i_row_done    (attn_row_done),
        .o_attn_ready  (attn_ready),
        .o_attn_empty  (attn_empty),
        .o_rd_data     (attn_data)
    );

    mm_calculator u_mm_calc (
        .s_clk           (s_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (start_q),
        .i_attn_empty    (attn_empty),
        .i_attn_data     (attn_data),
        .i_v_row         (v_row),
        .o_attn_rd_j     (attn_rd_j),
        .o_attn_row_done (attn_row_done),
        .o_v_addr        (v_addr),
        .o_spike_data    (o_spike_data),
        .o_spike_valid   (o_spike_valid),
        .o_spike_row     (o_spike_row),
        .o_done          (o_done),
        .o_busy          (calc_busy)
    );

endmodule

`default_nettype wire

// ==== hw/spk_attn_pkg.sv ====
`default_nettype none

package spk_attn_pkg;

    localparam int TOKENS        = 8;
    localparam int EMBED         = 8;
    localparam int TIME_STEPS    = 4;
    localparam int ROW_W         = EMBED * TIME_STEPS;  // bit t*EMBED+d is dim d at step t.
    localparam int TOK_AW        = 3;

    localparam int SCORE_W       = 4;                   // holds a match count of 0..8.
    localparam int SCORE_ROW_W   = SCORE_W * TIME_STEPS;
    localparam int PROD_W        = 7;                   // weighted sum over tokens, up to 64.
    localparam int MEM_W         = 8;
    localparam int LIF_THRESHOLD = 16;

    // load select codes.
    localparam int         SEL_W = 2;
    localparam logic [1:0] SEL_Q = 2'd0;
    localparam logic [1:0] SEL_K = 2'd1;
    localparam logic [1:0] SEL_V = 2'd2;

    // calculator FSM states.
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_WAIT  = 3'd1;
    localparam logic [2:0] ST_ACC   = 3'd2;
    localparam logic [2:0] ST_DRAIN = 3'd3;
    localparam logic [2:0] ST_LIF   = 3'd4;
    localparam logic [2:0] ST_FIN   = 3'd5;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module spike_attn_tb -f sim.f -o spike_attn_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/spike_attn_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== sim.f ====
hw/spk_attn_pkg.sv
hw/qkv_spike_ram.sv
hw/spike_accumulation.sv
hw/attn_score_buffer.sv
hw/mm_calculator.sv
hw/spike_attn_top.sv
sim/clk_gen.sv
sim/spike_attn_assertions.sv
sim/spike_attn_tb.sv

// ==== sim/clk_gen.sv ====
`default_nettype none

module clk_gen (
    output logic s_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        s_clk = 1'b0;
        forever #50 s_clk = ~s_clk;                     // 100 ns period.
    end

endmodule

`default_nettype wire

// ==== sim/spike_attn_assertions.sv ====
`default_nettype none

module spike_attn_assertions (
    input wire s_clk,
    input wire i_rst_n,
    input wire i_busy,
    input wire i_score_valid,
    input wire i_spike_valid,
    input wire i_done
);
    timeunit 1ns;
    timeprecision 1ps;

    a_quiet_in_reset: assert property (@(posedge s_clk)
        !i_rst_n |-> !(i_score_valid || i_spike_valid || i_done))
        else $error("valid output while reset is held");

    a_done_single: assert property (@(posedge s_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
        else $error("o_done high for more than one cycle");

    a_spike_busy: assert property (@(posedge s_clk) disable iff (!i_rst_n)
        i_spike_valid |-> i_busy)
        else $error("o_spike_valid while o_busy is low");

    a_done_idle: assert property (@(posedge s_clk) disable iff (!i_rst_n)
        i_done |-> !i_busy)                             // busy falls with done.
        else $error("o_busy still high with o_done");

endmodule

bind spike_attn_top spike_attn_assertions u_assert (
    .s_clk         (s_clk),
    .i_rst_n       (i_rst_n),
    .i_busy        (o_busy),
    .i_score_valid (o_score_valid),
    .i_spike_valid (o_spike_valid),
    .i_done        (o_done)
);

`default_nettype wire

// ==== sim/spike_attn_tb.sv ====
`default_nettype none

module spike_attn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES   = 7;
    localparam int NUM_PAIRS   = spk_attn_pkg::TOKENS * spk_attn_pkg::TOKENS;
    localparam int CYCLE_LIMIT = NUM_CASES * 1500 + 200;

    // kind 0 zeros, 1 ones, 2 checkerboard, 3 random, 4 random-sparse.
    int          case_kind   [NUM_CASES] = '{0, 1, 2, 3, 3, 4, 4};
    bit          case_reload [NUM_CASES] = '{1, 1, 1, 1, 0, 1, 0};
    bit          case_fixed  [NUM_CASES] = '{1, 1, 0, 0, 0, 0, 0};
    logic [15:0] case_score  [NUM_CASES] = '{16'h0, 16'h8888, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
    logic [31:0] case_spike  [NUM_CASES] = '{32'h0, 32'hffff_ffff, 32'h0, 32'h0, 32'h0,
                                            32'h0, 32'h0};

    logic        s_clk;
    logic        i_rst_n;
    logic        i_load_valid;
    logic [1:0]  i_load_sel;
    logic [2:0]  i_load_addr;
    logic [31:0] i_load_data;
    logic        i_start;
    logic        o_busy;
    logic        o_score_valid;
    logic [15:0] o_score_data;
    logic        o_spike_valid;
    logic [2:0]  o_spike_row;
    logic [31:0] o_spike_data;
    logic        o_done;

    logic [31:0] q_rows    [8];
    logic [31:0] k_rows    [8];
    logic [31:0] v_rows    [8];
    logic [15:0] exp_score [NUM_PAIRS];
    logic [31:0] exp_spike [8];
    int          cur_case    = 0;
    int          score_idx   = 0;
    int          spike_idx   = 0;
    int          cycle_cnt   = 0;
    bit          run_done    = 1'b0;
    bit          row7_seen   = 1'b0;

    clk_gen u_clk_gen (.s_clk(s_clk));

    spike_attn_top spike_attn_top_inst (
        .s_clk         (s_clk),
        .i_rst_n       (i_rst_n),
        .i_load_valid  (i_load_valid),
        .i_load_sel    (i_load_sel),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .i_start       (i_start),
        .o_busy        (o_busy),
        .o_score_valid (o_score_valid),
        .o_score_data  (o_score_data),
        .o_spike_valid (o_spike_valid),
        .o_spike_row   (o_spike_row),
        .o_spike_data  (o_spike_data),
        .o_done        (o_done)
    );

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] make_row(int kind, int mat, int row);
        case (kind)
            0: return '0;
            1: return '1;
            2: return ((row + mat) % 2) ? 32'h5555_5555 : 32'haaaa_aaaa;
            3: return $urandom;
            default: return $urandom & $urandom & $urandom;   // about one spike in eight.
        endcase
    endfunction

    // scores count common spikes per step, then LIF per dimension over the steps.
    task automatic build_expected();
        int cnt;
        int sum;
        int mem;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                for (int t = 0; t < 4; t++) begin
                    cnt = 0;
                    for (int d = 0; d < 8; d++) begin
                        cnt += q_rows[i][t*8 + d] & k_rows[j][t*8 + d];
                    end
                    exp_score[i*8 + j][t*4 +: 4] = cnt[3:0];
                end
            end
            for (int d = 0; d < 8; d++) begin
                mem = 0;
                for (int t = 0; t < 4; t++) begin
                    sum = 0;
                    for (int j = 0; j < 8; j++) begin
                        if (v_rows[j][t*8 + d]) sum += exp_score[i*8 + j][t*4 +: 4];
                    end
                    mem += sum;
                    exp_spike[i][t*8 + d] = (mem >= spk_attn_pkg::LIF_THRESHOLD);
                    if (mem >= spk_attn_pkg::LIF_THRESHOLD) mem = 0;
                end
            end
        end
    endtask

    task automatic load_case(int c);
        logic [31:0] row;
        for (int m = 0; m < 3; m++) begin
            for (int r = 0; r < 8; r++) begin
                row = make_row(case_kind[c], m, r);
                case (m)
                    0: q_rows[r] = row;
                    1: k_rows[r] = row;
                    default: v_rows[r] = row;
                endcase
                @(posedge s_clk);
                i_load_valid <= 1'b1;
                i_load_sel   <= m[1:0];
                i_load_addr  <= r[2:0];
                i_load_data  <= row;
            end
        end
        @(posedge s_clk);
        i_load_valid <= 1'b0;
    endtask

    task automatic run_case();
        build_expected();
        score_idx = 0;
        spike_idx = 0;
        run_done  = 1'b0;
        @(posedge s_clk);
        i_start <= 1'b1;
        @(posedge s_clk);
        i_start <= 1'b0;
        @(posedge s_clk);
        check_value("o_busy after i_start", o_busy, 1);
        // scores are all out, the calculator still works on the last rows.
        while (score_idx < NUM_PAIRS) @(posedge s_clk);
        check_value("o_busy before the late i_start", o_busy, 1);
        i_start <= 1'b1;                                // must be ignored while busy.
        @(posedge s_clk);
        i_start <= 1'b0;
        while (!run_done) @(posedge s_clk);
        check_value("score count", score_idx, NUM_PAIRS);
        check_value("spike row count", spike_idx, 8);
        repeat (2) @(posedge s_clk);
        check_value("o_busy between runs", o_busy, 0);
        check_value("o_score_valid between runs", o_score_valid, 0);
        check_value("o_spike_valid between runs", o_spike_valid, 0);
    endtask

    always @(posedge s_clk) begin
        if (i_rst_n) begin
            if (o_score_valid) begin
                if (score_idx >= NUM_PAIRS) begin
                    stop_on_error("score valid after the last pair of the run");
                end else begin
                    check_value($sformatf("o_score_data pair %0d", score_idx), o_score_data,
                                exp_score[score_idx]);
                    if (case_fixed[cur_case]) begin
                        check_value("o_score_data", o_score_data, case_score[cur_case]);
                    end
                    score_idx++;
                end
            end
            if (o_spike_valid) begin
                if (spike_idx >= 8) begin
                    stop_on_error("spike row valid after row 7 of the run");
                end else begin
                    check_value("o_spike_row", o_spike_row, spike_idx);
                    check_value($sformatf("o_spike_data row %0d", spike_idx), o_spike_data,
                                exp_spike[spike_idx]);
                    if (case_fixed[cur_case]) begin
                        check_value("o_spike_data", o_spike_data, case_spike[cur_case]);
                    end
                    spike_idx++;
                end
            end
            if (o_done) begin
                check_value("o_done follows row 7", row7_seen, 1);
                check_value("o_busy with o_done", o_busy, 0);
                run_done = 1'b1;
            end
            row7_seen = o_spike_valid && (o_spike_row == 3'd7);
        end
    end

    always @(posedge s_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: run did not end within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        i_rst_n      = 1'b0;
        i_load_valid = 1'b0;
        i_load_sel   = '0;
        i_load_addr  = '0;
        i_load_data  = '0;
        i_start      = 1'b0;
        void'($urandom(32'h42af));
        repeat (16) @(posedge s_clk);
        i_rst_n <= 1'b1;
        @(posedge s_clk);
        check_value("o_busy after reset", o_busy, 0);
        check_value("o_score_valid after reset", o_score_valid, 0);
        check_value("o_spike_valid after reset", o_spike_valid, 0);
        check_value("o_done after reset", o_done, 0);
        for (int c = 0; c < NUM_CASES; c++) begin
            cur_case = c;
            if (case_reload[c]) load_case(c);       // otherwise rerun on the same rows.
            run_case();
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
